// ==== common/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // Architectural register file
    localparam int ARF_SIZE  = 32;
    localparam int AREG_BITS = $clog2(ARF_SIZE);  // 5 bits

    // Physical register file
    localparam int PRF_SIZE  = 64;
    localparam int PREG_BITS = $clog2(PRF_SIZE);  // 6 bits

    // Registers not covered by the reset identity map
    localparam int FREE_COUNT = PRF_SIZE - ARF_SIZE;

    typedef logic [AREG_BITS-1:0] areg_id_t;  // x0..x31
    typedef logic [PREG_BITS-1:0] preg_id_t;  // p0..p63

endpackage

`default_nettype wire

// ==== rename/rename_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_ctrl (
    input  wire                   clk,
    input  wire                   rstn,
    // Decoded instruction in
    input  wire                   di_valid_i,
    input  wire rename_pkg::areg_id_t rs1_i,
    input  wire rename_pkg::areg_id_t rs2_i,
    input  wire rename_pkg::areg_id_t rd_i,
    input  wire                   rd_valid_i,
    input  wire [31:0]            pc_i,
    input  wire [7:0]             id_i,
    output logic                  di_ready_o,
    // Renamed instruction out
    output logic                  do_valid_o,
    output rename_pkg::preg_id_t  prs1_o,
    output rename_pkg::preg_id_t  prs2_o,
    output rename_pkg::preg_id_t  prd_o,
    output rename_pkg::areg_id_t  rd_o,
    output logic                  rd_valid_o,
    output logic [31:0]           pc_o,
    output logic [7:0]            id_o,
    input  wire                   do_ready_i,
    // Map table
    output rename_pkg::areg_id_t  rd_addr1_o,
    output rename_pkg::areg_id_t  rd_addr2_o,
    input  wire rename_pkg::preg_id_t map_prs1_i,
    input  wire rename_pkg::preg_id_t map_prs2_i,
    input  wire rename_pkg::preg_id_t map_old_prd_i,
    output logic                  map_we_o,
    output rename_pkg::areg_id_t  map_waddr_o,
    output rename_pkg::preg_id_t  map_wdata_o,
    // Free list
    output logic                  alloc_o,
    input  wire rename_pkg::preg_id_t free_prd_i,
    input  wire                   free_empty_i,
    // Retire queue
    output logic                  rq_push_o,
    output rename_pkg::preg_id_t  rq_old_prd_o,
    input  wire                   rq_full_i
);
    import rename_pkg::*;

    logic need_reg;
    logic stall;
    logic xfer;
    logic do_rename;

    assign need_reg = rd_valid_i && (rd_i != '0);  // x0 keeps p0 forever
    assign stall    = di_valid_i && need_reg && (free_empty_i || rq_full_i);

    assign do_valid_o = di_valid_i && !stall;
    assign di_ready_o = do_ready_i && !stall;

    // Both sides move on the same edge
    assign xfer      = di_valid_i && di_ready_o;
    assign do_rename = xfer && need_reg;

    // Allocate, remap and record always go together
    assign alloc_o      = do_rename;
    assign map_we_o     = do_rename;
    assign rq_push_o    = do_rename;
    assign map_waddr_o  = rd_i;
    assign map_wdata_o  = free_prd_i;
    assign rq_old_prd_o = map_old_prd_i;  // Previous owner of rd

    assign rd_addr1_o = rs1_i;
    assign rd_addr2_o = rs2_i;

    assign prs1_o     = map_prs1_i;
    assign prs2_o     = map_prs2_i;
    assign prd_o      = need_reg ? free_prd_i : '0;
    assign rd_o       = rd_i;
    assign rd_valid_o = need_reg;
    assign pc_o       = pc_i;
    assign id_o       = id_i;

    // The free list must never be popped dry
    a_no_alloc_empty: assert property (@(posedge clk) disable iff (!rstn)
        !(alloc_o && free_empty_i));

endmodule

`default_nettype wire

// ==== rename/rename_map.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_map (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire rename_pkg::areg_id_t raddr1_i,
    input  wire rename_pkg::areg_id_t raddr2_i,
    input  wire rename_pkg::areg_id_t raddr3_i,
    output rename_pkg::preg_id_t      rdata1_o,
    output rename_pkg::preg_id_t      rdata2_o,
    output rename_pkg::preg_id_t      rdata3_o,
    input  wire                       we_i,
    input  wire rename_pkg::areg_id_t waddr_i,
    input  wire rename_pkg::preg_id_t wdata_i
);
    import rename_pkg::*;

    preg_id_t map_q [ARF_SIZE];  // Current physical owner per arch reg

    // Combinational reads show the old value during a write
    assign rdata1_o = map_q[raddr1_i];
    assign rdata2_o = map_q[raddr2_i];
    assign rdata3_o = map_q[raddr3_i];  // Old mapping of rd

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ARF_SIZE; i++) begin
                map_q[i] <= preg_id_t'(i);  // Identity map
            end
        end else if (we_i) begin
            map_q[waddr_i] <= wdata_i;
        end
    end

    // The controller filters out x0 before it reaches the map
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rstn)
        we_i |-> (waddr_i != '0));

endmodule

`default_nettype wire

// ==== rename/free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       pop_i,
    output rename_pkg::preg_id_t      head_o,
    output logic                      empty_o,
    input  wire                       push_i,
    input  wire rename_pkg::preg_id_t push_data_i
);
    import rename_pkg::*;

    localparam int PTR_BITS = $clog2(FREE_COUNT);
    localparam int CNT_BITS = $clog2(FREE_COUNT + 1);

    preg_id_t            mem_q [FREE_COUNT];
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [CNT_BITS-1:0] count_q;

    assign head_o  = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = ARF_SIZE; i < PRF_SIZE; i++) begin
                mem_q[i - ARF_SIZE] <= preg_id_t'(i);  // p32..p63 ascending
            end
        end else if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;  // Write pointer meets read pointer when full
            count_q  <= CNT_BITS'(FREE_COUNT);
        end else begin
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;  // Wraps at FREE_COUNT
            end
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        pop_i |-> !empty_o);

    // A release beyond capacity means a tag was freed twice
    a_no_overfill: assert property (@(posedge clk) disable iff (!rstn)
        push_i |-> (count_q != CNT_BITS'(FREE_COUNT)));

endmodule

`default_nettype wire

// ==== verilog/retire_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module retire_queue #(
    parameter int RQ_DEPTH = 32
) (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       push_i,
    input  wire rename_pkg::preg_id_t push_data_i,
    output logic                      full_o,
    input  wire                       retire_i,
    output logic                      rel_valid_o,
    output rename_pkg::preg_id_t      rel_prd_o
);
    import rename_pkg::*;

    localparam int PTR_BITS = $clog2(RQ_DEPTH);
    localparam int CNT_BITS = $clog2(RQ_DEPTH + 1);

    preg_id_t            mem_q [RQ_DEPTH];  // Old tags in rename order
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [CNT_BITS-1:0] count_q;

    assign full_o      = (count_q == CNT_BITS'(RQ_DEPTH));
    assign rel_valid_o = retire_i;
    assign rel_prd_o   = mem_q[rd_ptr_q];  // Oldest recorded tag

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (retire_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // Depth is a power of two
            end
            if (push_i && !retire_i) begin
                count_q <= count_q + 1'b1;
            end else if (retire_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Retire pulses come from outside and must match recorded renames
    a_no_retire_empty: assert property (@(posedge clk) disable iff (!rstn)
        retire_i |-> (count_q != '0));

endmodule

`default_nettype wire

// ==== verilog/rename_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_top #(
    parameter int RQ_DEPTH = 32
) (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       di_valid_i,
    input  wire rename_pkg::areg_id_t rs1_i,
    input  wire rename_pkg::areg_id_t rs2_i,
    input  wire rename_pkg::areg_id_t rd_i,
    input  wire                       rd_valid_i,
    input  wire [31:0]                pc_i,
    input  wire [7:0]                 id_i,
    output logic                      di_ready_o,
    output logic                      do_valid_o,
    output rename_pkg::preg_id_t      prs1_o,
    output rename_pkg::preg_id_t      prs2_o,
    output rename_pkg::preg_id_t      prd_o,
    output rename_pkg::areg_id_t      rd_o,
    output logic                      rd_valid_o,
    output logic [31:0]               pc_o,
    output logic [7:0]                id_o,
    input  wire                       do_ready_i,
    input  wire                       retire_i
);
    import rename_pkg::*;

    areg_id_t rd_addr1, rd_addr2, map_waddr;
    preg_id_t map_prs1, map_prs2, map_old_prd, map_wdata;
    preg_id_t free_prd, rq_old_prd, rel_prd;
    logic     map_we, alloc, free_empty, rq_push, rq_full, rel_valid;

    rename_ctrl u_ctrl (
        .clk, .rstn,
        .di_valid_i, .rs1_i, .rs2_i, .rd_i, .rd_valid_i, .pc_i, .id_i, .di_ready_o,
        .do_valid_o, .prs1_o, .prs2_o, .prd_o, .rd_o, .rd_valid_o, .pc_o, .id_o,
        .do_ready_i,
        .rd_addr1_o(rd_addr1), .rd_addr2_o(rd_addr2),
        .map_prs1_i(map_prs1), .map_prs2_i(map_prs2), .map_old_prd_i(map_old_prd),
        .map_we_o(map_we), .map_waddr_o(map_waddr), .map_wdata_o(map_wdata),
        .alloc_o(alloc), .free_prd_i(free_prd), .free_empty_i(free_empty),
        .rq_push_o(rq_push), .rq_old_prd_o(rq_old_prd), .rq_full_i(rq_full)
    );

    rename_map u_map (
        .clk, .rstn,
        .raddr1_i(rd_addr1), .raddr2_i(rd_addr2), .raddr3_i(rd_i),  // Port 3 reads rd
        .rdata1_o(map_prs1), .rdata2_o(map_prs2), .rdata3_o(map_old_prd),
        .we_i(map_we), .waddr_i(map_waddr), .wdata_i(map_wdata)
    );

    free_list u_free (
        .clk, .rstn,
        .pop_i(alloc), .head_o(free_prd), .empty_o(free_empty),
        .push_i(rel_valid), .push_data_i(rel_prd)  // Released tags come back here
    );

    retire_queue #(.RQ_DEPTH(RQ_DEPTH)) u_rq (
        .clk, .rstn,
        .push_i(rq_push), .push_data_i(rq_old_prd), .full_o(rq_full),
        .retire_i, .rel_valid_o(rel_valid), .rel_prd_o(rel_prd)
    );

endmodule

`default_nettype wire

// ==== tests/tb_rename.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rename;
    import rename_pkg::*;

    localparam int RQ_DEPTH = 32;
    localparam int TIMEOUT  = 20;  // Cycles allowed per handshake

    logic        clk;
    logic        rstn;
    logic        di_valid_i, rd_valid_i, do_ready_i, retire_i;
    areg_id_t    rs1_i, rs2_i, rd_i, rd_o;
    logic [31:0] pc_i, pc_o;
    logic [7:0]  id_i, id_o;
    logic        di_ready_o, do_valid_o, rd_valid_o;
    preg_id_t    prs1_o, prs2_o, prd_o;

    // Reference model state
    preg_id_t    ref_map [ARF_SIZE];
    preg_id_t    free_mem [FREE_COUNT];
    preg_id_t    rq_mem [RQ_DEPTH];
    logic [4:0]  free_rd, free_wr, rq_rd, rq_wr;
    int          free_cnt, rq_cnt, xfer_count;
    logic        exp_need, exp_stall, exp_xfer;
    preg_id_t    exp_prs1, exp_prs2, exp_prd;

    int          err_hs, err_tag, guard;
    logic [31:0] seed;
    logic [4:0]  r;

    rename_top #(.RQ_DEPTH(RQ_DEPTH)) uut (.*);

    always #50 clk = ~clk;

    assign exp_need  = rd_valid_i && (rd_i != '0);
    assign exp_stall = di_valid_i && exp_need && (free_cnt == 0 || rq_cnt == RQ_DEPTH);
    assign exp_xfer  = di_valid_i && do_ready_i && !exp_stall;
    assign exp_prs1  = ref_map[rs1_i];
    assign exp_prs2  = ref_map[rs2_i];
    assign exp_prd   = exp_need ? free_mem[free_rd] : '0;

    always @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ARF_SIZE; i++) begin
                ref_map[i]  <= preg_id_t'(i);
                free_mem[i] <= preg_id_t'(ARF_SIZE + i);
            end
            {free_rd, free_wr, rq_rd, rq_wr} <= '0;
            free_cnt   <= FREE_COUNT;
            rq_cnt     <= 0;
            xfer_count <= 0;
        end else begin
            if (di_valid_i && di_ready_o) xfer_count <= xfer_count + 1;  // DUT handshake
            if (exp_xfer && exp_need) begin
                ref_map[rd_i] <= free_mem[free_rd];
                rq_mem[rq_wr] <= ref_map[rd_i];  // Old owner in rename order
                free_rd       <= free_rd + 1'b1;
                rq_wr         <= rq_wr + 1'b1;
            end
            if (retire_i) begin
                free_mem[free_wr] <= rq_mem[rq_rd];
                free_wr           <= free_wr + 1'b1;
                rq_rd             <= rq_rd + 1'b1;
            end
            free_cnt <= free_cnt - int'(exp_xfer && exp_need) + int'(retire_i);
            rq_cnt   <= rq_cnt + int'(exp_xfer && exp_need) - int'(retire_i);
        end
    end

    a_ready: assert property (@(posedge clk) disable iff (!rstn)
        di_ready_o == (do_ready_i && !exp_stall))
        else begin
            err_hs++;
            $display("Error at %0t: di_ready_o is %0b", $time, di_ready_o);
        end

    a_valid: assert property (@(posedge clk) disable iff (!rstn)
        do_valid_o == (di_valid_i && !exp_stall))
        else begin
            err_hs++;
            $display("Error at %0t: do_valid_o is %0b", $time, do_valid_o);
        end

    // Fields are checked whenever the instruction is shown
    a_fields: assert property (@(posedge clk) disable iff (!rstn)
        (di_valid_i && !exp_stall) |-> (prs1_o == exp_prs1 && prs2_o == exp_prs2
            && prd_o == exp_prd && rd_valid_o == exp_need && rd_o == rd_i
            && pc_o == pc_i && id_o == id_i))
        else begin
            err_tag++;
            $display("Error at %0t: id %0d got prs1 %0d prs2 %0d prd %0d, expected %0d %0d %0d",
                $time, id_i, prs1_o, prs2_o, prd_o, exp_prs1, exp_prs2, exp_prd);
        end

    function automatic logic [4:0] next_areg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[28:24];
    endfunction

    function automatic logic [4:0] next_dest();
        return 5'(next_areg() % 5'd31) + 5'd1;  // Never x0
    endfunction

    // Called at a falling edge; holds do_ready_i low for bp_cycles first
    task automatic send_instr(input logic [4:0] s1, s2, d, input logic dv, input int bp_cycles);
        int start;
        int waited;
        di_valid_i = 1'b1;
        rs1_i      = s1;
        rs2_i      = s2;
        rd_i       = d;
        rd_valid_i = dv;
        pc_i       = pc_i + 32'd4;
        id_i       = id_i + 8'd1;
        if (bp_cycles > 0) begin
            do_ready_i = 1'b0;
            repeat (bp_cycles) @(negedge clk);
            do_ready_i = 1'b1;
        end
        start  = xfer_count;
        waited = 0;
        while (xfer_count == start && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (xfer_count == start) begin
            $display("Timeout: instruction %0d was never accepted", id_i);
            $display("Simulation failed");
            $finish;
        end else begin
            di_valid_i = 1'b0;
        end
    endtask

    task automatic hold_stalled(input logic [4:0] d);
        di_valid_i = 1'b1;
        rd_i       = d;
        rd_valid_i = 1'b1;
        id_i       = id_i + 8'd1;
        repeat (4) @(negedge clk);  // Handshake must stay low throughout
        di_valid_i = 1'b0;
    endtask

    task automatic retire_one();
        retire_i = 1'b1;
        @(negedge clk);
        retire_i = 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        di_valid_i = 1'b0;
        rd_valid_i = 1'b0;
        do_ready_i = 1'b1;
        retire_i   = 1'b0;
        {rs1_i, rs2_i, rd_i} = '0;
        pc_i       = 32'h1000;
        id_i       = 8'd0;
        seed       = 32'h2458;
        err_hs     = 0;
        err_tag    = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        send_instr(5'd5, 5'd7, 5'd0, 1'b0, 0);     // Identity map after reset
        send_instr(5'd31, 5'd1, 5'd0, 1'b1, 0);    // x0 destination
        send_instr(5'd1, 5'd2, 5'd10, 1'b1, 0);
        send_instr(5'd10, 5'd10, 5'd11, 1'b1, 0);  // Reads the new tag of x10
        send_instr(5'd11, 5'd4, 5'd12, 1'b0, 0);   // rd not written
        send_instr(5'd12, 5'd11, 5'd12, 1'b1, 3);  // Back-pressure

        guard = 0;
        while (free_cnt != 0 && guard < 2 * FREE_COUNT) begin
            send_instr(next_areg(), next_areg(), next_dest(), 1'b1, 0);
            guard++;
        end

        hold_stalled(5'd7);                        // Free list exhausted
        send_instr(5'd7, 5'd8, 5'd9, 1'b0, 0);     // No rd, still passes

        repeat (8) retire_one();
        repeat (8) send_instr(next_areg(), next_areg(), next_dest(), 1'b1, 0);

        for (int i = 0; i < 80; i++) begin
            r = next_areg();
            if ((r[3] || free_cnt == 0) && rq_cnt != 0) begin
                retire_one();
            end else begin
                send_instr(next_areg(), next_areg(), next_areg(), r[1] | r[0], r[4] ? 1 : 0);
            end
        end
        repeat (2) @(negedge clk);

        $display("Checks done: %0d handshake errors, %0d field errors", err_hs, err_tag);
        if (err_hs == 0 && err_tag == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
common/rename_pkg.sv
rename/rename_ctrl.sv
rename/rename_map.sv
rename/free_list.sv
verilog/retire_queue.sv
verilog/rename_top.sv
tests/tb_rename.sv

// ==== Bender.yml ====
package:
  name: rename

sources:
  - common/rename_pkg.sv
  - rename/rename_ctrl.sv
  - rename/rename_map.sv
  - rename/free_list.sv
  - verilog/retire_queue.sv
  - verilog/rename_top.sv
  - target: test
    files:
      - tests/tb_rename.sv
